// File: source/isaPkg.sv
package isaPkg;

    typedef logic [15:0] wordT;
    typedef logic [1:0] regIndexT;
    typedef logic [15:0] addressT;

    typedef enum logic [3:0] {
        BNE = 4'd0,
        BEQ = 4'd1,
        BGZ = 4'd2,
        BLZ = 4'd3,
        ADI = 4'd4,
        ORI = 4'd5,
        LHI = 4'd6,
        LWD = 4'd7,
        SWD = 4'd8,
        JMP = 4'd9,
        JAL = 4'd10,
        RTYPE = 4'd15
    } opcodeT;

    // Jumps and system ops sit above the ALU func codes
    typedef enum logic [5:0] {
        ADD = 6'd0,
        SUB = 6'd1,
        AND = 6'd2,
        ORR = 6'd3,
        NOT = 6'd4,
        TCP = 6'd5,
        SHL = 6'd6,
        SHR = 6'd7,
        JPR = 6'd25,
        JRL = 6'd26,
        WWD = 6'd28,
        HLT = 6'd29
    } funcT;

endpackage

// File: source/pipePkg.sv
package pipePkg;
    import isaPkg::*;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_TCP,
        ALU_SHL,
        ALU_SHR,
        ALU_LHI,
        ALU_PASSA,
        ALU_BNE,
        ALU_BEQ,
        ALU_BGZ,
        ALU_BLZ
    } aluOpT;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } forwardSelT;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic memWrite;
        logic memRead;
        logic isBranch;
        logic aluSrc;
        logic isJumpReg;
        logic isJumpImm;
        logic linkWrite;
        logic writeOutput;
        logic isHalt;
        logic usesRs;
        logic usesRt;
        aluOpT aluOp;
    } controlT;

    typedef struct packed {
        addressT pc;
        wordT instruction;
        logic valid;
    } ifIdT;

    typedef struct packed {
        addressT pc;
        controlT control;
        wordT readData1;
        wordT readData2;
        regIndexT rs;
        regIndexT rt;
        regIndexT rd;
        wordT imm;
        logic valid;
    } idExT;

    typedef struct packed {
        controlT control;
        wordT aluResult;
        wordT storeData;
        regIndexT rd;
        logic valid;
    } exMemT;

    typedef struct packed {
        controlT control;
        wordT aluResult;
        wordT loadData;
        regIndexT rd;
        logic valid;
    } memWbT;

    typedef struct packed {
        logic read;
        logic write;
        addressT address;
        wordT writeData;
    } memRequestT;

endpackage

// File: source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input wordT instruction,
    output controlT control
);

    opcodeT opcode;
    funcT func;
    logic isRtype;

    assign opcode = opcodeT'(instruction[15:12]);
    assign func = funcT'(instruction[5:0]);
    assign isRtype = (opcode == RTYPE);

    always_comb begin
        control = '0;
        control.aluOp = ALU_PASSA;
        case (opcode)
            BNE: control.aluOp = ALU_BNE;
            BEQ: control.aluOp = ALU_BEQ;
            BGZ: control.aluOp = ALU_BGZ;
            BLZ: control.aluOp = ALU_BLZ;
            ADI, LWD, SWD: control.aluOp = ALU_ADD;
            ORI: control.aluOp = ALU_OR;
            LHI: control.aluOp = ALU_LHI;
            RTYPE: begin
                case (func)
                    ADD: control.aluOp = ALU_ADD;
                    SUB: control.aluOp = ALU_SUB;
                    AND: control.aluOp = ALU_AND;
                    ORR: control.aluOp = ALU_OR;
                    NOT: control.aluOp = ALU_NOT;
                    TCP: control.aluOp = ALU_TCP;
                    SHL: control.aluOp = ALU_SHL;
                    SHR: control.aluOp = ALU_SHR;
                    default: control.aluOp = ALU_PASSA;
                endcase
            end
            default: control.aluOp = ALU_PASSA;
        endcase

        control.isBranch = opcode inside {BNE, BEQ, BGZ, BLZ};
        control.aluSrc = opcode inside {ADI, ORI, LHI, LWD, SWD};
        control.memRead = (opcode == LWD);
        control.memToReg = (opcode == LWD);
        control.memWrite = (opcode == SWD);
        control.isJumpImm = opcode inside {JMP, JAL};
        control.isJumpReg = isRtype && (func inside {JPR, JRL});
        // Link into register 2
        control.linkWrite = (opcode == JAL) || (isRtype && func == JRL);
        control.writeOutput = isRtype && (func == WWD);
        control.isHalt = isRtype && (func == HLT);
        control.regWrite = (opcode inside {ADI, ORI, LHI, LWD, JAL})
            || (isRtype && (func inside {ADD, SUB, AND, ORR, NOT, TCP, SHL, SHR, JRL}));
        control.usesRs = !(opcode inside {LHI, JMP, JAL}) && !(isRtype && func == HLT);
        control.usesRt = (opcode inside {BNE, BEQ, SWD})
            || (isRtype && (func inside {ADD, SUB, AND, ORR}));
    end

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ps

module registerFile
    import isaPkg::*;
(
    input logic Clk,
    input logic reset,
    input regIndexT readIndex1,
    input regIndexT readIndex2,
    input regIndexT writeIndex,
    input wordT writeData,
    input logic writeEnable,
    output wordT readData1,
    output wordT readData2
);

    wordT registers [4];

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable) begin
            registers[writeIndex] <= writeData;
        end
    end

    // Writeback value bypasses the array in the same cycle
    assign readData1 = (writeEnable && writeIndex == readIndex1) ? writeData
                                                                 : registers[readIndex1];
    assign readData2 = (writeEnable && writeIndex == readIndex2) ? writeData
                                                                 : registers[readIndex2];

endmodule

// File: source/executeUnit.sv
`timescale 1ns/1ps

module executeUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input wordT operandA,
    input wordT operandB,
    input wordT immediate,
    input logic aluSrc,
    input aluOpT aluOp,
    output wordT result,
    output logic branchTaken
);

    wordT secondOperand;

    assign secondOperand = aluSrc ? immediate : operandB;

    always_comb begin
        result = operandA + secondOperand;
        branchTaken = 1'b0;
        case (aluOp)
            ALU_ADD: result = operandA + secondOperand;
            ALU_SUB: result = operandA - secondOperand;
            ALU_AND: result = operandA & secondOperand;
            ALU_OR: result = operandA | secondOperand;
            ALU_NOT: result = ~operandA;
            ALU_TCP: result = ~operandA + 16'd1;
            ALU_SHL: result = {operandA[14:0], 1'b0};
            // Arithmetic shift keeps the sign
            ALU_SHR: result = {operandA[15], operandA[15:1]};
            ALU_LHI: result = {immediate[7:0], 8'h00};
            ALU_PASSA: result = operandA;
            // Branch compares ignore the immediate
            ALU_BNE: branchTaken = (operandA != operandB);
            ALU_BEQ: branchTaken = (operandA == operandB);
            ALU_BGZ: branchTaken = ($signed(operandA) > 0);
            ALU_BLZ: branchTaken = ($signed(operandA) < 0);
            default: result = operandA;
        endcase
    end

endmodule

// File: source/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input regIndexT exRs,
    input regIndexT exRt,
    input regIndexT memRd,
    input logic memRegWrite,
    input logic memValid,
    input regIndexT wbRd,
    input logic wbRegWrite,
    input logic wbValid,
    input regIndexT idRs,
    input regIndexT idRt,
    input logic idUsesRs,
    input logic idUsesRt,
    input logic exMemRead,
    input regIndexT exRd,
    output forwardSelT forwardA,
    output forwardSelT forwardB,
    output logic loadStall
);

    // Memory stage holds the younger producer, so it is checked first
    function automatic forwardSelT selectSource(regIndexT source);
        if (memValid && memRegWrite && memRd == source) begin
            return FWD_MEM;
        end else if (wbValid && wbRegWrite && wbRd == source) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign forwardA = selectSource(exRs);
    assign forwardB = selectSource(exRt);

    // Bubbles carry cleared control, so memRead marks a valid load
    assign loadStall = exMemRead
        && ((idUsesRs && idRs == exRd) || (idUsesRt && idRt == exRd));

endmodule

// File: source/sharedMemory.sv
`timescale 1ns/1ps

module sharedMemory
    import isaPkg::*;
    import pipePkg::*;
(
    input logic Clk,
    input logic reset,
    input addressT fetchAddress,
    output wordT fetchData,
    output logic fetchGrant,
    input memRequestT dataRequest,
    output wordT loadData,
    input logic loadEnable,
    input addressT loadAddress,
    input wordT hostData
);

    localparam int Depth = 256;

    wordT memory [Depth];
    logic dataActive;
    addressT portAddress;
    wordT readWord;

    // Data access always wins the single port
    assign dataActive = dataRequest.read | dataRequest.write;
    assign fetchGrant = ~dataActive;
    assign portAddress = dataActive ? dataRequest.address : fetchAddress;

    assign readWord = memory[portAddress[7:0]];
    assign fetchData = readWord;
    assign loadData = readWord;

    always_ff @(posedge Clk) begin
        if (reset) begin
            // Host program load
            if (loadEnable) begin
                memory[loadAddress[7:0]] <= hostData;
            end
        end else if (dataRequest.write) begin
            memory[portAddress[7:0]] <= dataRequest.writeData;
        end
    end

endmodule

// File: source/datapath.sv
`timescale 1ns/1ps

module datapath
    import isaPkg::*;
    import pipePkg::*;
(
    input logic Clk,
    input logic reset,
    output wordT instruction,
    input controlT control,
    output regIndexT readIndex1,
    output regIndexT readIndex2,
    output regIndexT writeIndex,
    output wordT writeData,
    output logic writeEnable,
    input wordT readData1,
    input wordT readData2,
    output regIndexT exRs,
    output regIndexT exRt,
    output regIndexT memRd,
    output logic memRegWrite,
    output logic memValid,
    output regIndexT wbRd,
    output logic wbRegWrite,
    output logic wbValid,
    output regIndexT idRs,
    output regIndexT idRt,
    output logic idUsesRs,
    output logic idUsesRt,
    output logic exMemRead,
    output regIndexT exRd,
    input forwardSelT forwardA,
    input forwardSelT forwardB,
    input logic loadStall,
    output wordT operandA,
    output wordT operandB,
    output wordT immediate,
    output logic aluSrc,
    output aluOpT aluOp,
    input wordT result,
    input logic branchTaken,
    output addressT fetchAddress,
    input wordT fetchData,
    input logic fetchGrant,
    output memRequestT dataRequest,
    input wordT loadData,
    output wordT outputPort,
    output logic outputValid,
    output logic halted,
    output wordT retiredCount
);

    ifIdT ifId;
    idExT idEx;
    exMemT exMem;
    memWbT memWb;
    addressT pc;
    addressT nextPc;
    logic haltFetch;
    wordT decodeImm;
    regIndexT decodeRd;
    addressT jumpTarget;
    addressT branchTarget;
    logic jumpFlush;
    logic haltDecode;
    logic branchFlush;

    // Decode
    assign instruction = ifId.instruction;
    assign idRs = ifId.instruction[11:10];
    assign idRt = ifId.instruction[9:8];
    assign readIndex1 = idRs;
    assign readIndex2 = idRt;
    assign idUsesRs = ifId.valid & control.usesRs;
    assign idUsesRt = ifId.valid & control.usesRt;

    // ORI takes a zero-extended immediate
    assign decodeImm = (control.aluSrc && control.aluOp == ALU_OR)
        ? {8'h00, ifId.instruction[7:0]} : {{8{ifId.instruction[7]}}, ifId.instruction[7:0]};
    assign decodeRd = control.linkWrite ? 2'd2
        : (ifId.instruction[15:12] == RTYPE) ? ifId.instruction[7:6] : ifId.instruction[9:8];
    assign jumpTarget = {ifId.pc[15:12], ifId.instruction[11:0]};
    assign jumpFlush = ifId.valid & control.isJumpImm;
    assign haltDecode = ifId.valid & control.isHalt;

    // Execute
    assign exRs = idEx.rs;
    assign exRt = idEx.rt;
    assign exRd = idEx.rd;
    assign exMemRead = idEx.control.memRead;
    assign writeData = memWb.control.memToReg ? memWb.loadData : memWb.aluResult;
    assign operandA = (forwardA == FWD_MEM) ? exMem.aluResult
                    : (forwardA == FWD_WB) ? writeData : idEx.readData1;
    assign operandB = (forwardB == FWD_MEM) ? exMem.aluResult
                    : (forwardB == FWD_WB) ? writeData : idEx.readData2;
    assign immediate = idEx.imm;
    assign aluSrc = idEx.control.aluSrc;
    assign aluOp = idEx.control.aluOp;
    assign branchTarget = idEx.pc + 16'd1 + idEx.imm;
    assign branchFlush = idEx.valid
        & ((idEx.control.isBranch & branchTaken) | idEx.control.isJumpReg);

    // Memory and writeback
    assign memRd = exMem.rd;
    assign memRegWrite = exMem.control.regWrite;
    assign memValid = exMem.valid;
    assign dataRequest = '{read: exMem.valid & exMem.control.memRead,
                           write: exMem.valid & exMem.control.memWrite,
                           address: exMem.aluResult,
                           writeData: exMem.storeData};
    assign wbRd = memWb.rd;
    assign wbRegWrite = memWb.control.regWrite;
    assign wbValid = memWb.valid;
    assign writeIndex = memWb.rd;
    assign writeEnable = memWb.valid & memWb.control.regWrite;

    assign fetchAddress = pc;

    always_comb begin
        if (branchFlush && idEx.control.isBranch) begin
            nextPc = branchTarget;
        end else if (branchFlush) begin
            nextPc = operandA;
        end else if (jumpFlush) begin
            nextPc = jumpTarget;
        end else if (loadStall || !fetchGrant || haltFetch || haltDecode) begin
            nextPc = pc;
        end else begin
            nextPc = pc + 16'd1;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            ifId.valid <= 1'b0;
            idEx.valid <= 1'b0;
            idEx.control <= '0;
            exMem.valid <= 1'b0;
            exMem.control <= '0;
            memWb.valid <= 1'b0;
            memWb.control <= '0;
        end else begin
            if (branchFlush) begin
                ifId.valid <= 1'b0;
            end else if (!loadStall) begin
                if (jumpFlush || haltDecode || haltFetch || !fetchGrant) begin
                    ifId.valid <= 1'b0;
                end else begin
                    ifId <= '{pc: pc, instruction: fetchData, valid: 1'b1};
                end
            end

            if (branchFlush || loadStall || !ifId.valid) begin
                idEx.valid <= 1'b0;
                idEx.control <= '0;
            end else begin
                idEx <= '{pc: ifId.pc, control: control, readData1: readData1,
                          readData2: readData2, rs: idRs, rt: idRt, rd: decodeRd,
                          imm: decodeImm, valid: 1'b1};
            end

            exMem <= '{control: idEx.control,
                       aluResult: idEx.control.linkWrite ? idEx.pc + 16'd1 : result,
                       storeData: operandB, rd: idEx.rd, valid: idEx.valid};
            memWb <= '{control: exMem.control, aluResult: exMem.aluResult,
                       loadData: loadData, rd: exMem.rd, valid: exMem.valid};
        end
    end

    // PC, halt and retire bookkeeping
    always_ff @(posedge Clk) begin
        if (reset) begin
            pc <= '0;
            haltFetch <= 1'b0;
            outputPort <= '0;
            outputValid <= 1'b0;
            halted <= 1'b0;
            retiredCount <= '0;
        end else begin
            pc <= nextPc;
            haltFetch <= haltFetch | (haltDecode & ~branchFlush);
            outputValid <= memWb.valid & memWb.control.writeOutput;
            if (memWb.valid && memWb.control.writeOutput) begin
                outputPort <= memWb.aluResult;
            end
            if (memWb.valid) begin
                retiredCount <= retiredCount + 16'd1;
            end
            if (memWb.valid && memWb.control.isHalt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// File: source/cpuTop.sv
`timescale 1ns/1ps

module cpuTop
    import isaPkg::*;
    import pipePkg::*;
(
    input logic Clk,
    input logic reset,
    input logic loadEnable,
    input addressT loadAddress,
    input wordT hostData,
    output wordT outputPort,
    output logic outputValid,
    output logic halted,
    output wordT retiredCount
);

    wordT instruction;
    controlT control;
    regIndexT readIndex1, readIndex2, writeIndex;
    wordT writeData, readData1, readData2;
    logic writeEnable;
    regIndexT exRs, exRt, exRd, memRd, wbRd, idRs, idRt;
    logic memRegWrite, memValid, wbRegWrite, wbValid;
    logic idUsesRs, idUsesRt, exMemRead, loadStall;
    forwardSelT forwardA, forwardB;
    wordT operandA, operandB, immediate, result;
    logic aluSrc, branchTaken;
    aluOpT aluOp;
    addressT fetchAddress;
    wordT fetchData, loadData;
    logic fetchGrant;
    memRequestT dataRequest;

    datapath datapath_i (.*);
    controlUnit controlUnit_i (.*);
    registerFile registerFile_i (.*);
    executeUnit executeUnit_i (.*);
    hazardUnit hazardUnit_i (.*);
    sharedMemory sharedMemory_i (.*);

endmodule

// File: test/cpuTopTb.sv
`timescale 1ns/1ps

module cpuTopTb
    import isaPkg::*;
();

    localparam int ClockPeriod = 20;
    localparam int ResetCycles = 4;
    localparam int HaltLimit = 2000;
    localparam int QuietCycles = 10;

    logic Clk;
    logic reset;
    logic loadEnable;
    addressT loadAddress;
    wordT hostData;
    wordT outputPort;
    logic outputValid;
    logic halted;
    wordT retiredCount;

    // Length, program, output count, outputs, retired count
    wordT fileWords [128];
    int programLength;
    int outputCount;
    int outputsSeen;

    cpuTop dut_i (.*);

    initial begin
        Clk = 1'b0;
        forever begin
            #(ClockPeriod / 2) Clk = ~Clk;
        end
    end

    function automatic wordT fileWord(int position);
        return fileWords[7'(position)];
    endfunction

    task automatic stopRun();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compareValue(input wordT actual, input wordT expected, input string what);
        if (actual !== expected) begin
            $display("Fail at time %0d ns: %s is %h, expected %h",
                     $time, what, actual, expected);
            stopRun();
        end
    endtask

    // One word per cycle through the host port
    task automatic loadProgram();
        for (int i = 0; i < programLength; i++) begin
            @(posedge Clk);
            loadEnable <= 1'b1;
            loadAddress <= addressT'(i);
            hostData <= fileWord(i + 1);
        end
        @(posedge Clk);
        loadEnable <= 1'b0;
    endtask

    task automatic checkOutput();
        if (outputsSeen < outputCount) begin
            compareValue(outputPort, fileWord(programLength + 2 + outputsSeen), "output port");
            outputsSeen++;
        end else begin
            $display("Output port pulsed at time %0d ns with no value left to expect", $time);
            stopRun();
        end
    endtask

    initial begin
        int cycles;

        reset = 1'b1;
        loadEnable = 1'b0;
        loadAddress = '0;
        hostData = '0;
        outputsSeen = 0;
        $readmemh("test/program_input.txt", fileWords);
        programLength = int'(fileWord(0));
        outputCount = int'(fileWord(programLength + 1));

        // Core stays in reset through the idle cycles and the program load
        repeat (ResetCycles) @(posedge Clk);
        loadProgram();
        @(posedge Clk);
        reset <= 1'b0;

        @(negedge Clk);
        compareValue(retiredCount, 16'd0, "retired count after reset");
        compareValue(outputPort, 16'd0, "output port after reset");
        compareValue(wordT'(halted), 16'd0, "halted after reset");
        compareValue(wordT'(outputValid), 16'd0, "output valid after reset");

        // Outputs sampled mid-cycle until the core halts
        cycles = 0;
        while (!halted && cycles < HaltLimit) begin
            @(negedge Clk);
            cycles++;
            if (outputValid) begin
                checkOutput();
            end
        end
        if (!halted) begin
            $display("Timeout: the core did not halt within %0d cycles", HaltLimit);
            stopRun();
        end

        compareValue(wordT'(outputsSeen), wordT'(outputCount), "number of output values");
        compareValue(retiredCount, fileWord(programLength + 2 + outputCount), "retired count");

        // Nothing may leave the core once halted
        for (int i = 0; i < QuietCycles; i++) begin
            @(negedge Clk);
            compareValue(wordT'(outputValid), 16'd0, "output valid after halt");
            compareValue(wordT'(halted), 16'd1, "halted level");
        end
        compareValue(retiredCount, fileWord(programLength + 2 + outputCount),
                     "retired count after halt");

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: test/program_input.txt
// Hex words: program length, program, output count, expected WWD values, retired count
// Program loads from address 0, the store and load use address 0x80
002E
// 0-3 LHI, ORI, ADI, ADD
6112 55B4 42FD F6C0
// 4-7 WWD r3, SUB, TCP, WWD r0
FC1C FD01 F005 F01C
// 8-11 AND, ORR, SHL, WWD r1
F742 F443 F446 F41C
// 12-15 NOT, SHR, WWD r3, ADI r0 to the data area
F4C4 FCC7 FC1C 407D
// 16-19 SWD, LWD, dependent ADD, WWD r2
8300 7100 F580 F81C
// 20-23 BNE not taken, BEQ taken, skipped, BLZ taken
0701 1701 F01C 3802
// 24-27 two skipped, BGZ not taken, BGZ taken
F81C F41C 2801 2001
// 28-31 skipped, BNE taken, skipped, BEQ not taken
FC1C 0101 F01C 1101
// 32-35 BLZ not taken, JAL to 36, two skipped
3001 A024 F01C F41C
// 36-39 WWD link, ADI, JPR to 41, skipped
F81C 4907 F419 F41C
// 40-43 skipped, WWD r1, JMP to 44, skipped
F81C F41C 902C F01C
// 44-45 HLT and the word behind it
F01D FC1C
// Expected WWD values
0007
12B1 0003 2566 ED4C DA98 0022 0029
// Retired instructions
0023

// File: cpuTop.f
source/isaPkg.sv
source/pipePkg.sv
source/controlUnit.sv
source/registerFile.sv
source/executeUnit.sv
source/hazardUnit.sv
source/sharedMemory.sv
source/datapath.sv
source/cpuTop.sv
test/cpuTopTb.sv

// File: run.sh
#!/bin/sh
# Build the core with its testbench, run it and look for the pass line
verilator --binary --timing --top-module cpuTopTb -f cpuTop.f -o cpuTopSim &&
    ./obj_dir/cpuTopSim | tee /dev/stderr | grep -q "TEST PASS" &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
